/* source/ctrl_cfg.svh */
`ifndef CTRL_CFG_SVH
`define CTRL_CFG_SVH

// Datapath geometry
`define CTRL_XLEN       32
`define CTRL_NIBBLE     4

// Register file addressing
`define CTRL_REG_AW     5

// Microcode sequencing
// Index covers up to 8 micro-ops per instruction
`define CTRL_UIDX_W     3
// Repeat counter, enough for a full 32-bit pass at one nibble per cycle
`define CTRL_REP_W      5

// --------------------
// CSR space
// --------------------
`define CTRL_CSR_AW     12
// Status register written by CSRW
`define CTRL_CSR_STATUS 12'h7C0

`endif

/* source/isa_pkg.sv */
package isa_pkg;

  // --------------------
  // Decoded instruction
  // --------------------

  // One entry per supported RV32 instruction
  // Anything else decodes to OP_NOP and runs as an 8-cycle bubble
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_ADDI = 4'd5,
    OP_ANDI = 4'd6,
    OP_ORI  = 4'd7,
    OP_XORI = 4'd8,
    OP_LUI  = 4'd9,
    OP_CSRW = 4'd10,
    OP_NOP  = 4'd15
  } opcode_e;

  // --------------------
  // Immediate formats
  // --------------------

  // I is sign-extended ir[31:20], U is ir[31:12] with 12 zero bits below
  typedef enum logic [1:0] {
    IMM_I    = 2'b00,
    IMM_U    = 2'b01,
    IMM_NONE = 2'b11
  } imm_fmt_e;

endpackage

/* source/uctrl_pkg.sv */
`include "ctrl_cfg.svh"

package uctrl_pkg;
  import isa_pkg::*;

  // ALU result select
  typedef enum logic [1:0] {
    ARITH = 2'b00,
    LOGIC = 2'b01
  } alu_type_e;

  // Bitwise function of the logic unit
  typedef enum logic [1:0] {
    XOR = 2'b00,
    OR  = 2'b10,
    AND = 2'b11
  } logic_fn_e;

  // Carry into the adder for each nibble
  typedef enum logic [1:0] {
    CARRY_0    = 2'b00,
    CARRY_1    = 2'b01,
    CARRY_PROP = 2'b10
  } carry_e;

  // --------------------
  // Control word
  // --------------------
  typedef struct packed {
    logic [`CTRL_REP_W-1:0]  rep_count;
    logic                    a_pc;       // A operand from PC side
    logic [`CTRL_REG_AW-1:0] rega_addr;
    logic [`CTRL_REG_AW-1:0] regb_addr;
    logic [`CTRL_REG_AW-1:0] wb_addr;
    logic                    wb_en;
    logic                    imm_load;
    logic                    imm_shift;
    imm_fmt_e                imm_fmt;
    logic                    imm_zero;
    logic                    b_reg;      // B operand from register file
    logic                    sub;
    carry_e                  carry;
    logic_fn_e               logic_fn;
    alu_type_e               alu_type;
    logic                    flag_en;
    logic                    csr_wen;
    logic                    last;
  } uop_word_t;

  // Idle word, issued while no instruction is in flight
  localparam uop_word_t UOP_DEFAULT = '{
    rep_count: '0, a_pc: 1'b1, rega_addr: '0, regb_addr: '0, wb_addr: '0,
    wb_en: 1'b0, imm_load: 1'b0, imm_shift: 1'b0, imm_fmt: IMM_NONE,
    imm_zero: 1'b1, b_reg: 1'b0, sub: 1'b0, carry: CARRY_0, logic_fn: AND,
    alu_type: ARITH, flag_en: 1'b0, csr_wen: 1'b0, last: 1'b0
  };

endpackage

/* source/fetch_sequencer.sv */
`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module fetch_sequencer (
  input  logic                    clk,
  input  logic                    reset,
  output logic                    imem_req_val_o,
  input  logic                    imem_req_rdy_i,
  input  logic                    imem_resp_val_i,
  output logic                    imem_resp_rdy_o,
  input  logic [`CTRL_XLEN-1:0]   imem_resp_data_i,
  input  logic [`CTRL_REP_W-1:0]  rep_count_i,
  input  logic                    last_uop_d_i,
  input  logic                    last_uop_x_i,
  output logic [`CTRL_XLEN-1:0]   ir_o,
  output logic [`CTRL_UIDX_W-1:0] uop_idx_o,
  output logic                    uop_active_o
);

  logic                    req_q;
  logic                    pend_q;
  logic                    active_q;
  logic                    first_q;
  logic [`CTRL_REP_W-1:0]  cnt_q;
  logic [`CTRL_REP_W-1:0]  cnt_cur;
  logic [`CTRL_UIDX_W-1:0] idx_q;
  logic [`CTRL_XLEN-1:0]   ir_q;
  logic                    fin_r_q;
  logic                    fin_x_q;
  logic                    req_xfer;
  logic                    resp_xfer;
  logic                    uop_done;
  logic                    last_issue;

  // --------------------
  // Fetch handshake
  // --------------------
  assign imem_req_val_o  = req_q;
  assign imem_resp_rdy_o = pend_q;
  assign req_xfer        = req_q & imem_req_rdy_i;
  assign resp_xfer       = imem_resp_val_i & pend_q;

  // Repeat count comes straight from the ROM on the first cycle of a micro-op
  assign cnt_cur    = first_q ? rep_count_i : cnt_q;
  assign uop_done   = active_q && (cnt_cur == '0);
  assign last_issue = uop_done && last_uop_d_i;

  always_ff @(posedge clk) begin
    if (reset) begin
      req_q    <= 1'b1;
      pend_q   <= 1'b0;
      active_q <= 1'b0;
      first_q  <= 1'b0;
      cnt_q    <= '0;
      idx_q    <= '0;
      fin_r_q  <= 1'b0;
      fin_x_q  <= 1'b0;
    end else begin
      // Next fetch starts once the final cycle of the last micro-op is in X
      if (req_xfer) begin
        req_q <= 1'b0;
      end else if (fin_x_q && last_uop_x_i) begin
        req_q <= 1'b1;
      end

      if (resp_xfer) begin
        pend_q <= 1'b0;
      end else if (req_xfer) begin
        pend_q <= 1'b1;
      end

      // Micro-op sequencing
      if (resp_xfer) begin
        active_q <= 1'b1;
        first_q  <= 1'b1;
        idx_q    <= '0;
      end else if (active_q) begin
        first_q <= uop_done;
        if (uop_done) begin
          idx_q <= idx_q + 1'b1;
        end else begin
          cnt_q <= cnt_cur - 1'b1;
        end
        if (last_issue) begin
          active_q <= 1'b0;
        end
      end

      // Follows the final issue cycle down to X
      fin_r_q <= last_issue;
      fin_x_q <= fin_r_q;
    end
  end

  // Instruction register
  always_ff @(posedge clk) begin
    if (resp_xfer) begin
      ir_q <= imem_resp_data_i;
    end
  end

  assign ir_o         = ir_q;
  assign uop_idx_o    = idx_q;
  assign uop_active_o = active_q;

endmodule

/* source/microcode_rom.sv */
`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module microcode_rom import isa_pkg::*, uctrl_pkg::*; (
  input  logic [`CTRL_XLEN-1:0]   ir_i,
  input  logic [`CTRL_UIDX_W-1:0] uop_idx_i,
  input  logic                    uop_active_i,
  output uop_word_t               uop_o
);

  logic [`CTRL_REG_AW-1:0] rs1;
  logic [`CTRL_REG_AW-1:0] rs2;
  logic [`CTRL_REG_AW-1:0] rd;
  opcode_e                 op;
  logic                    is_reg;
  logic                    is_arith;
  uop_word_t               word;

  assign rs1 = ir_i[19:15];
  assign rs2 = ir_i[24:20];
  assign rd  = ir_i[11:7];

  // --------------------
  // Instruction decode
  // --------------------
  always_comb begin
    casez (ir_i)
      32'b0000000_?????_?????_000_?????_0110011: op = OP_ADD;
      32'b0100000_?????_?????_000_?????_0110011: op = OP_SUB;
      32'b0000000_?????_?????_111_?????_0110011: op = OP_AND;
      32'b0000000_?????_?????_110_?????_0110011: op = OP_OR;
      32'b0000000_?????_?????_100_?????_0110011: op = OP_XOR;
      32'b???????_?????_?????_000_?????_0010011: op = OP_ADDI;
      32'b???????_?????_?????_111_?????_0010011: op = OP_ANDI;
      32'b???????_?????_?????_110_?????_0010011: op = OP_ORI;
      32'b???????_?????_?????_100_?????_0010011: op = OP_XORI;
      32'b???????_?????_?????_???_?????_0110111: op = OP_LUI;
      // csrrw with rd = x0
      32'b???????_?????_?????_001_00000_1110011: op = OP_CSRW;
      default:                                   op = OP_NOP;
    endcase
  end

  assign is_reg   = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
  assign is_arith = op inside {OP_ADD, OP_SUB, OP_ADDI, OP_LUI};

  // --------------------
  // Micro-op tables
  // --------------------
  always_comb begin
    word = UOP_DEFAULT;
    case (op)
      OP_CSRW: begin
        // rs1 is streamed for 7 cycles, the write lands on the 8th
        word.a_pc      = 1'b0;
        word.rega_addr = rs1;
        if (uop_idx_i == '0) begin
          word.rep_count = `CTRL_REP_W'(6);
        end else begin
          word.csr_wen = 1'b1;
          word.last    = 1'b1;
        end
      end
      OP_NOP: begin
        word.rep_count = `CTRL_REP_W'(7);
        word.last      = 1'b1;
      end
      default: begin
        // ALU ops, LUI adds its immediate to x0
        word.a_pc      = 1'b0;
        word.rega_addr = (op == OP_LUI) ? '0 : rs1;
        word.regb_addr = is_reg ? rs2 : '0;
        word.wb_addr   = rd;
        word.wb_en     = 1'b1;
        word.imm_fmt   = (op == OP_LUI) ? IMM_U : (is_reg ? IMM_NONE : IMM_I);
        word.imm_zero  = is_reg;
        word.b_reg     = is_reg;
        word.sub       = (op == OP_SUB);
        word.flag_en   = is_arith;
        word.alu_type  = is_arith ? ARITH : LOGIC;
        if (op inside {OP_XOR, OP_XORI}) begin
          word.logic_fn = XOR;
        end else if (op inside {OP_OR, OP_ORI}) begin
          word.logic_fn = OR;
        end else begin
          word.logic_fn = AND;
        end
        case (uop_idx_i)
          'd0: begin
            word.carry    = (op == OP_SUB) ? CARRY_1 : CARRY_0;
            word.imm_load = !is_reg;
          end
          'd1: begin
            word.rep_count = `CTRL_REP_W'(5);
            word.carry     = CARRY_PROP;
            word.imm_shift = !is_reg;
          end
          default: begin
            word.carry     = CARRY_PROP;
            word.imm_shift = !is_reg;
            word.last      = 1'b1;
          end
        endcase
      end
    endcase
  end

  assign uop_o = uop_active_i ? word : UOP_DEFAULT;

endmodule

/* source/imm_streamer.sv */
`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module imm_streamer import isa_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`CTRL_XLEN-1:0]   ir_i,
  input  logic                    imm_load_i,
  input  logic                    imm_shift_i,
  input  imm_fmt_e                imm_fmt_i,
  output logic [`CTRL_NIBBLE-1:0] imm_nib_o
);

  logic [`CTRL_XLEN-1:0] imm_sel;
  logic [`CTRL_XLEN-1:0] imm_q;

  // Immediate extraction
  always_comb begin
    case (imm_fmt_i)
      IMM_I:   imm_sel = {{(`CTRL_XLEN-12){ir_i[`CTRL_XLEN-1]}}, ir_i[`CTRL_XLEN-1:20]};
      IMM_U:   imm_sel = {ir_i[`CTRL_XLEN-1:12], 12'b0};
      default: imm_sel = '0;
    endcase
  end

  // Shift register, least significant nibble goes out first
  always_ff @(posedge clk) begin
    if (reset) begin
      imm_q <= '0;
    end else if (imm_load_i) begin
      imm_q <= imm_sel;
    end else if (imm_shift_i) begin
      imm_q <= imm_q >> `CTRL_NIBBLE;
    end
  end

  assign imm_nib_o = imm_q[`CTRL_NIBBLE-1:0];

endmodule

/* source/uop_pipeline.sv */
`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module uop_pipeline import uctrl_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  uop_word_t               uop_i,
  input  logic [`CTRL_CSR_AW-1:0] csr_addr_i,
  input  logic [`CTRL_NIBBLE-1:0] imm_nib_i,
  input  logic [`CTRL_XLEN-1:0]   proc2cop_data_i,
  output logic [`CTRL_REG_AW-1:0] rega_addr_o,
  output logic [`CTRL_REG_AW-1:0] regb_addr_o,
  output logic [`CTRL_REG_AW-1:0] wb_addr_o,
  output logic                    wb_en_o,
  output logic                    a_mux_sel_o,
  output logic                    b_mux_sel_o,
  output logic                    addsub_fn_o,
  output logic                    carry_in_1_o,
  output logic                    prop_carry_o,
  output logic                    flag_reg_en_o,
  output logic                    last_uop_o,
  output logic_fn_e               logic_fn_o,
  output alu_type_e               alu_fn_type_o,
  output logic [`CTRL_NIBBLE-1:0] b_imm_o,
  output logic [`CTRL_XLEN-1:0]   cp0_status_o
);

  uop_word_t               uop_r_q;
  uop_word_t               uop_x_q;
  logic [`CTRL_NIBBLE-1:0] b_imm_x_q;
  logic [`CTRL_CSR_AW-1:0] csr_addr_r_q;
  logic [`CTRL_CSR_AW-1:0] csr_addr_x_q;
  logic [`CTRL_XLEN-1:0]   status_q;

  // --------------------
  // D -> R -> X
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      uop_r_q   <= UOP_DEFAULT;
      uop_x_q   <= UOP_DEFAULT;
      b_imm_x_q <= '0;
      status_q  <= '0;
    end else begin
      uop_r_q   <= uop_i;
      uop_x_q   <= uop_r_q;
      // Immediate nibble is valid in R, zeroed for register operands
      b_imm_x_q <= uop_r_q.imm_zero ? '0 : imm_nib_i;
      if (uop_x_q.csr_wen && (csr_addr_x_q == `CTRL_CSR_STATUS)) begin
        status_q <= proc2cop_data_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    csr_addr_r_q <= csr_addr_i;
    csr_addr_x_q <= csr_addr_r_q;
  end

  // Register file reads are issued from R
  assign rega_addr_o = uop_r_q.rega_addr;
  assign regb_addr_o = uop_r_q.regb_addr;

  // Execute stage outputs
  assign wb_addr_o     = uop_x_q.wb_addr;
  assign wb_en_o       = uop_x_q.wb_en;
  assign a_mux_sel_o   = uop_x_q.a_pc;
  assign b_mux_sel_o   = uop_x_q.b_reg;
  assign addsub_fn_o   = uop_x_q.sub;
  assign carry_in_1_o  = (uop_x_q.carry == CARRY_1);
  assign prop_carry_o  = (uop_x_q.carry == CARRY_PROP);
  assign flag_reg_en_o = uop_x_q.flag_en;
  assign last_uop_o    = uop_x_q.last;
  assign logic_fn_o    = uop_x_q.logic_fn;
  assign alu_fn_type_o = uop_x_q.alu_type;
  assign b_imm_o       = b_imm_x_q;
  assign cp0_status_o  = status_q;

endmodule

/* source/ctrl_top.sv */
`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module ctrl_top import uctrl_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  output logic                    imem_req_val_o,
  input  logic                    imem_req_rdy_i,
  input  logic                    imem_resp_val_i,
  output logic                    imem_resp_rdy_o,
  input  logic [`CTRL_XLEN-1:0]   imem_resp_data_i,
  input  logic [`CTRL_XLEN-1:0]   proc2cop_data_i,
  output logic [`CTRL_REG_AW-1:0] rega_addr_o,
  output logic [`CTRL_REG_AW-1:0] regb_addr_o,
  output logic [`CTRL_REG_AW-1:0] wb_addr_o,
  output logic                    wb_en_o,
  output logic                    a_mux_sel_o,
  output logic                    b_mux_sel_o,
  output logic                    addsub_fn_o,
  output logic                    carry_in_1_o,
  output logic                    prop_carry_o,
  output logic                    flag_reg_en_o,
  output logic                    last_uop_o,
  output logic_fn_e               logic_fn_o,
  output alu_type_e               alu_fn_type_o,
  output logic [`CTRL_NIBBLE-1:0] b_imm_o,
  output logic [`CTRL_XLEN-1:0]   cp0_status_o
);

  logic [`CTRL_XLEN-1:0]   ir;
  logic [`CTRL_UIDX_W-1:0] uop_idx;
  logic                    uop_active;
  uop_word_t               uop_d;
  logic [`CTRL_NIBBLE-1:0] imm_nib;

  fetch_sequencer u_fetch (
    .clk              (clk),
    .reset            (reset),
    .imem_req_val_o   (imem_req_val_o),
    .imem_req_rdy_i   (imem_req_rdy_i),
    .imem_resp_val_i  (imem_resp_val_i),
    .imem_resp_rdy_o  (imem_resp_rdy_o),
    .imem_resp_data_i (imem_resp_data_i),
    .rep_count_i      (uop_d.rep_count),
    .last_uop_d_i     (uop_d.last),
    .last_uop_x_i     (last_uop_o),
    .ir_o             (ir),
    .uop_idx_o        (uop_idx),
    .uop_active_o     (uop_active)
  );

  microcode_rom u_rom (
    .ir_i         (ir),
    .uop_idx_i    (uop_idx),
    .uop_active_i (uop_active),
    .uop_o        (uop_d)
  );

  imm_streamer u_imm (
    .clk         (clk),
    .reset       (reset),
    .ir_i        (ir),
    .imm_load_i  (uop_d.imm_load),
    .imm_shift_i (uop_d.imm_shift),
    .imm_fmt_i   (uop_d.imm_fmt),
    .imm_nib_o   (imm_nib)
  );

  // CSR address field sits in ir[31:20]
  uop_pipeline u_pipe (
    .clk             (clk),
    .reset           (reset),
    .uop_i           (uop_d),
    .csr_addr_i      (ir[`CTRL_XLEN-1 -: `CTRL_CSR_AW]),
    .imm_nib_i       (imm_nib),
    .proc2cop_data_i (proc2cop_data_i),
    .rega_addr_o     (rega_addr_o),
    .regb_addr_o     (regb_addr_o),
    .wb_addr_o       (wb_addr_o),
    .wb_en_o         (wb_en_o),
    .a_mux_sel_o     (a_mux_sel_o),
    .b_mux_sel_o     (b_mux_sel_o),
    .addsub_fn_o     (addsub_fn_o),
    .carry_in_1_o    (carry_in_1_o),
    .prop_carry_o    (prop_carry_o),
    .flag_reg_en_o   (flag_reg_en_o),
    .last_uop_o      (last_uop_o),
    .logic_fn_o      (logic_fn_o),
    .alu_fn_type_o   (alu_fn_type_o),
    .b_imm_o         (b_imm_o),
    .cp0_status_o    (cp0_status_o)
  );

endmodule

/* testbench/ctrl_tb.sv */
`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module ctrl_tb import isa_pkg::*, uctrl_pkg::*; ();

  localparam int NUM_INSTR  = 40;
  localparam int WAIT_LIMIT = 200;

  // Expected X-stage behavior of one instruction
  typedef struct packed {
    logic [3:0]  wb_cycles;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        use_imm;
    logic [31:0] imm;
    alu_type_e   alu_type;
    logic        chk_logic;
    logic_fn_e   logic_fn;
    logic        sub;
    logic        arith;
    logic        status_wr;
  } summary_t;

  // One observed write-back cycle
  typedef struct packed {
    logic [3:0] nib;
    logic [4:0] addr;
    logic [4:0] ra;
    logic [4:0] rb;
    logic       asel;
    logic       bsel;
    logic       sub;
    logic       cin;
    logic       prop;
    logic [1:0] alu_t;
    logic [1:0] fn;
  } xcycle_t;

  logic                    clk;
  logic                    reset;
  logic                    imem_req_val_o;
  logic                    imem_req_rdy_i;
  logic                    imem_resp_val_i;
  logic                    imem_resp_rdy_o;
  logic [`CTRL_XLEN-1:0]   imem_resp_data_i;
  logic [`CTRL_XLEN-1:0]   proc2cop_data_i;
  logic [`CTRL_REG_AW-1:0] rega_addr_o;
  logic [`CTRL_REG_AW-1:0] regb_addr_o;
  logic [`CTRL_REG_AW-1:0] wb_addr_o;
  logic                    wb_en_o;
  logic                    a_mux_sel_o;
  logic                    b_mux_sel_o;
  logic                    addsub_fn_o;
  logic                    carry_in_1_o;
  logic                    prop_carry_o;
  logic                    flag_reg_en_o;
  logic                    last_uop_o;
  logic_fn_e               logic_fn_o;
  alu_type_e               alu_fn_type_o;
  logic [`CTRL_NIBBLE-1:0] b_imm_o;
  logic [`CTRL_XLEN-1:0]   cp0_status_o;

  logic [31:0] prog [NUM_INSTR];
  logic [31:0] exp_q [$];
  xcycle_t     seen [8];
  int unsigned seed;
  int          error_count = 0;
  int          pulse_count = 0;
  int          done_count  = 0;
  int          wb_cnt      = 0;
  logic        last_prev   = 1'b0;
  logic        req_stalled = 1'b0;
  logic [4:0]  rega_prev   = '0;
  logic [4:0]  regb_prev   = '0;
  logic [31:0] status_data = '0;
  logic [31:0] exp_status  = '0;

  ctrl_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    proc2cop_data_i <= $urandom();
  end

  // --------------------
  // Failure reporting
  // --------------------
  task automatic stop_run();
    error_count++;
    $display("Errors found");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("ERROR %s: instruction %0d expected 0x%0h actual 0x%0h",
             name, done_count, expected, actual);
    stop_run();
  endtask

  task automatic report_failure(input string what);
    $display("FAILURE at %0t ns: %s", $time, what);
    stop_run();
  endtask

  // --------------------
  // Reference model
  // --------------------
  function automatic summary_t expected_summary(input logic [31:0] instr);
    summary_t   s;
    opcode_e    op;
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    opc = instr[6:0];
    f3  = instr[14:12];
    f7  = instr[31:25];
    op  = OP_NOP;
    if (opc == 7'h33 && f7 == 7'h00) begin
      case (f3)
        3'd0:    op = OP_ADD;
        3'd4:    op = OP_XOR;
        3'd6:    op = OP_OR;
        3'd7:    op = OP_AND;
        default: op = OP_NOP;
      endcase
    end else if (opc == 7'h33 && f7 == 7'h20 && f3 == 3'd0) begin
      op = OP_SUB;
    end else if (opc == 7'h13) begin
      case (f3)
        3'd0:    op = OP_ADDI;
        3'd4:    op = OP_XORI;
        3'd6:    op = OP_ORI;
        3'd7:    op = OP_ANDI;
        default: op = OP_NOP;
      endcase
    end else if (opc == 7'h37) begin
      op = OP_LUI;
    end else if (opc == 7'h73 && f3 == 3'd1 && instr[11:7] == 5'd0) begin
      op = OP_CSRW;
    end

    s = '0;
    s.rd        = instr[11:7];
    s.status_wr = (op == OP_CSRW) && (instr[31:20] == `CTRL_CSR_STATUS);
    if (!(op inside {OP_CSRW, OP_NOP})) begin
      s.wb_cycles = 4'd8;
      s.use_imm   = op inside {OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
      // LUI reads x0 so the adder passes the immediate through
      s.rs1       = (op == OP_LUI) ? 5'd0 : instr[19:15];
      s.rs2       = instr[24:20];
      // U immediate fills the upper 20 bits and I immediate is sign-extended
      s.imm       = (op == OP_LUI) ? {instr[31:12], 12'h000} : {{20{instr[31]}}, instr[31:20]};
      s.arith     = op inside {OP_ADD, OP_SUB, OP_ADDI, OP_LUI};
      s.alu_type  = s.arith ? ARITH : LOGIC;
      s.chk_logic = !s.arith;
      s.sub       = (op == OP_SUB);
      if (op inside {OP_XOR, OP_XORI}) begin
        s.logic_fn = XOR;
      end else if (op inside {OP_OR, OP_ORI}) begin
        s.logic_fn = OR;
      end else begin
        s.logic_fn = AND;
      end
    end
    return s;
  endfunction

  // Kinds 0-9 give ALU ops and kinds 10-11 give CSRW
  // Other kinds decode as NOP
  function automatic logic [31:0] random_instr(input int kind);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [11:0] csr;
    r0  = $urandom();
    r1  = $urandom();
    csr = (r1[11:0] == 12'h7C0) ? 12'h7C1 : r1[11:0];
    case (kind)
      0:  return {7'h00, r0[24:20], r0[19:15], 3'd0, r0[11:7], 7'h33};
      1:  return {7'h20, r0[24:20], r0[19:15], 3'd0, r0[11:7], 7'h33};
      2:  return {7'h00, r0[24:20], r0[19:15], 3'd7, r0[11:7], 7'h33};
      3:  return {7'h00, r0[24:20], r0[19:15], 3'd6, r0[11:7], 7'h33};
      4:  return {7'h00, r0[24:20], r0[19:15], 3'd4, r0[11:7], 7'h33};
      5:  return {r1[31:20], r0[19:15], 3'd0, r0[11:7], 7'h13};
      6:  return {r1[31:20], r0[19:15], 3'd7, r0[11:7], 7'h13};
      7:  return {r1[31:20], r0[19:15], 3'd6, r0[11:7], 7'h13};
      8:  return {r1[31:20], r0[19:15], 3'd4, r0[11:7], 7'h13};
      9:  return {r1[31:12], r0[11:7], 7'h37};
      10: return {12'h7C0, r0[19:15], 3'd1, 5'd0, 7'h73};
      11: return {csr, r0[19:15], 3'd1, 5'd0, 7'h73};
      12: return {r1[31:20], r0[19:15], 3'd2, r0[11:7], 7'h13};
      default: return {r1[31:7], 7'h63};
    endcase
  endfunction

  // --------------------
  // Instruction memory
  // --------------------
  task automatic serve_fetch(input int k, input logic [31:0] instr);
    int delay;
    int t;
    delay = $urandom_range(5, 0);
    if (delay == 0) begin
      imem_req_rdy_i <= 1'b1;
    end
    t = 0;
    @(negedge clk);
    while (!imem_req_val_o) begin
      t++;
      if (t > WAIT_LIMIT) report_failure("instruction request never arrived");
      @(negedge clk);
    end
    // Hold off the request for a few cycles once it shows up
    if (delay > 0) begin
      repeat (delay) @(posedge clk);
      imem_req_rdy_i <= 1'b1;
      @(negedge clk);
    end
    // Fetches and last_uop_o pulses alternate
    assert (pulse_count == k) else report_mismatch("fetch order", k, pulse_count);
    @(posedge clk);
    imem_req_rdy_i <= 1'b0;

    delay = $urandom_range(5, 0);
    repeat (delay) @(posedge clk);
    imem_resp_val_i  <= 1'b1;
    imem_resp_data_i <= instr;
    t = 0;
    @(negedge clk);
    while (!(imem_resp_val_i && imem_resp_rdy_o)) begin
      t++;
      if (t > WAIT_LIMIT) report_failure("response was never accepted");
      @(negedge clk);
    end
    exp_q.push_back(instr);
    @(posedge clk);
    imem_resp_val_i  <= 1'b0;
    imem_resp_data_i <= $urandom();
  endtask

  // --------------------
  // X-stage monitor
  // --------------------
  task automatic check_instruction(input logic [31:0] instr);
    summary_t s;
    int       i;
    s = expected_summary(instr);
    assert (wb_cnt == s.wb_cycles) else report_mismatch("wb_en cycles", s.wb_cycles, wb_cnt);
    for (i = 0; i < s.wb_cycles; i++) begin
      assert (seen[i].addr == s.rd) else report_mismatch("wb_addr", s.rd, seen[i].addr);
      assert (seen[i].ra == s.rs1) else report_mismatch("rega_addr", s.rs1, seen[i].ra);
      assert (s.use_imm || seen[i].rb == s.rs2)
        else report_mismatch("regb_addr", s.rs2, seen[i].rb);
      assert (seen[i].asel == 1'b0) else report_mismatch("a_mux_sel", 0, seen[i].asel);
      assert (seen[i].alu_t == s.alu_type)
        else report_mismatch("alu_fn_type", s.alu_type, seen[i].alu_t);
      assert (seen[i].sub == s.sub) else report_mismatch("addsub_fn", s.sub, seen[i].sub);
      assert (!s.chk_logic || seen[i].fn == s.logic_fn)
        else report_mismatch("logic_fn", s.logic_fn, seen[i].fn);
      assert (seen[i].bsel == !s.use_imm)
        else report_mismatch("b_mux_sel", !s.use_imm, seen[i].bsel);
      assert (!s.use_imm || seen[i].nib == s.imm[4*i +: 4])
        else report_mismatch("b_imm", s.imm[4*i +: 4], seen[i].nib);
      if (s.arith && i == 0) begin
        assert (seen[i].cin == s.sub) else report_mismatch("carry_in_1", s.sub, seen[i].cin);
      end
      if (s.arith && i > 0) begin
        assert (seen[i].prop) else report_mismatch("prop_carry", 1, seen[i].prop);
      end
    end
    if (s.status_wr) begin
      exp_status = status_data;
    end
  endtask

  always @(negedge clk) begin
    if (!reset) begin
      assert (!req_stalled || imem_req_val_o)
        else report_failure("imem_req_val_o dropped while imem_req_rdy_i was low");
      assert (!(imem_req_val_o || imem_resp_rdy_o) || !wb_en_o)
        else report_failure("wb_en_o was high during an instruction fetch");
      assert (wb_en_o || !flag_reg_en_o)
        else report_failure("flag_reg_en_o was high outside a write-back cycle");
      req_stalled = imem_req_val_o && !imem_req_rdy_i;

      if (last_uop_o && !last_prev) begin
        pulse_count++;
      end
      if (wb_en_o) begin
        if (wb_cnt < 8) begin
          seen[wb_cnt].nib   = b_imm_o;
          seen[wb_cnt].addr  = wb_addr_o;
          seen[wb_cnt].ra    = rega_prev;
          seen[wb_cnt].rb    = regb_prev;
          seen[wb_cnt].asel  = a_mux_sel_o;
          seen[wb_cnt].bsel  = b_mux_sel_o;
          seen[wb_cnt].sub   = addsub_fn_o;
          seen[wb_cnt].cin   = carry_in_1_o;
          seen[wb_cnt].prop  = prop_carry_o;
          seen[wb_cnt].alu_t = alu_fn_type_o;
          seen[wb_cnt].fn    = logic_fn_o;
        end
        wb_cnt++;
      end
      if (last_uop_o) begin
        status_data = proc2cop_data_i;
      end

      // Pulse has ended so the instruction is complete
      if (last_prev && !last_uop_o) begin
        assert (exp_q.size() > 0)
          else report_failure("last_uop_o pulse without a fetched instruction");
        check_instruction(exp_q.pop_front());
        wb_cnt = 0;
        done_count++;
      end
      last_prev = last_uop_o;

      // Register addresses lead the X stage by one cycle
      rega_prev = rega_addr_o;
      regb_prev = regb_addr_o;

      assert (cp0_status_o == exp_status)
        else report_mismatch("cp0_status", exp_status, cp0_status_o);
    end
  end

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    int k;
    int t;
    seed = 32'hec6e;
    void'($urandom(seed));
    reset            = 1'b1;
    imem_req_rdy_i   = 1'b0;
    imem_resp_val_i  = 1'b0;
    imem_resp_data_i = '0;
    proc2cop_data_i  = '0;

    // A few CSR writes are placed on purpose
    for (k = 0; k < NUM_INSTR; k++) begin
      if (k % 10 == 3) begin
        prog[k] = random_instr(10);
      end else if (k % 10 == 7) begin
        prog[k] = random_instr(11);
      end else begin
        prog[k] = random_instr($urandom_range(13, 0));
      end
    end

    repeat (2) @(posedge clk);
    reset <= 1'b0;

    for (k = 0; k < NUM_INSTR; k++) begin
      serve_fetch(k, prog[k]);
    end

    t = 0;
    while (done_count < NUM_INSTR) begin
      @(posedge clk);
      t++;
      if (t > WAIT_LIMIT) report_failure("the last instruction never completed");
    end
    repeat (2) @(posedge clk);
    assert (exp_q.size() == 0) else report_failure("instructions left without a last_uop_o pulse");

    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+source
source/isa_pkg.sv
source/uctrl_pkg.sv
source/fetch_sequencer.sv
source/microcode_rom.sv
source/imm_streamer.sv
source/uop_pipeline.sv
source/ctrl_top.sv
testbench/ctrl_tb.sv
